// ==== i2c_master.f ====
source/i2c_pkg.sv
source/i2c_bit_engine.sv
source/i2c_frame_ctrl.sv
source/i2c_master.sv
sim/i2c_master_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the i2c_master testbench with Verilator.
# Exit status is 0 only when the log holds no failure report.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_i2c_master
LOG_FILE=sim.log

verilator --binary --timing -j 0 \
    --top-module i2c_master_tb \
    --Mdir "$BUILD_DIR" -o "$SIM_BIN" \
    -f i2c_master.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

if grep -q "Checks failed" "$LOG_FILE"; then
    echo "FAIL: testbench reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "FAIL: simulation exited with status $sim_status"
    exit 1
fi

echo "PASS"
exit 0

// ==== sim/i2c_master_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_master_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int CLKS_PER_TICK = 4;
    localparam int N_TXN         = 200;
    localparam int TICKS_PER_TXN = 150;  // 116 nominal plus stretch and turnaround
    localparam int WATCHDOG_NS   = N_TXN * TICKS_PER_TXN * CLKS_PER_TICK * CLK_PERIOD + 20000;
    localparam int NO_NACK       = 3;    // slave acks every byte
    localparam logic [31:0] SEED = 32'h775de624;

    logic                  CLK = 1'b0;
    logic                  NRST;
    logic                  tick;
    logic                  start;
    i2c_pkg::i2c_request_t request;

    wire i2c_pkg::bus_pins_t           pins;
    wire                               busy;
    wire                               nack_seen;
    wire [i2c_pkg::COUNT_W-1:0]        command_count;
    wire [i2c_pkg::COUNT_W-1:0]        data_count;
    wire i2c_pkg::frame_state_t        state;

    // wired-AND bus, either side may pull low
    logic slave_scl_pull = 1'b0;
    logic slave_sda_pull = 1'b0;
    wire  scl_line;
    wire  sda_line;

    assign scl_line = !(pins.scl_oe || slave_scl_pull);
    assign sda_line = !(pins.sda_oe || slave_sda_pull);

    // slave model state
    logic       rst_seen;
    logic       tick_seen;
    logic       scl_now;
    logic       sda_now;
    logic       prev_scl;
    logic       prev_sda;
    logic       in_txn;
    int         bit_cnt;
    int         byte_idx;
    int         stretch_left;
    logic [7:0] shift_in;
    logic [7:0] got_bytes[$];  // bytes seen on the bus this transaction
    int         stop_cnt;

    // per-transaction slave behaviour, set by the stimulus
    int nack_at;
    int stretch_ticks;

    // reference model
    logic [31:0]                 lfsr_state;
    logic [i2c_pkg::COUNT_W-1:0] exp_command_count;
    logic [i2c_pkg::COUNT_W-1:0] exp_data_count;

    i2c_master DUT (
        .CLK           (CLK),
        .NRST          (NRST),
        .tick          (tick),
        .start         (start),
        .request       (request),
        .scl_in        (scl_line),
        .sda_in        (sda_line),
        .pins          (pins),
        .busy          (busy),
        .nack_seen     (nack_seen),
        .command_count (command_count),
        .data_count    (data_count),
        .state         (state)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // one tick every four clocks, free running
    initial begin
        logic [1:0] tick_div;
        tick_div = 2'd0;
        tick     = 1'b0;
        forever begin
            @(posedge CLK);
            #1;
            tick_div = tick_div + 2'd1;
            tick     = (tick_div == 2'd0);
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s (got %0h, expected %0h)", $time, what,
                     actual, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // right-shift Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // slave: samples the lines after the DUT edge, then updates its own pulls
    always @(posedge CLK) begin
        rst_seen  = NRST;
        tick_seen = tick;
        #1;
        scl_now = scl_line;
        sda_now = sda_line;
        if (!rst_seen) begin
            in_txn         = 1'b0;
            bit_cnt        = 0;
            byte_idx       = 0;
            stop_cnt       = 0;
            stretch_left   = 0;
            slave_scl_pull = 1'b0;
            slave_sda_pull = 1'b0;
            prev_scl       = 1'b1;
            prev_sda       = 1'b1;
        end else begin
            if (prev_scl && scl_now && (sda_now != prev_sda)) begin
                // SDA moving under high SCL is only legal as start or stop
                if (!sda_now) begin
                    check(32'(in_txn), 32'd0, "start condition inside a transaction");
                    in_txn   = 1'b1;
                    bit_cnt  = 0;
                    byte_idx = 0;
                    stop_cnt = 0;
                    got_bytes.delete();
                end else begin
                    check(32'(in_txn), 32'd1, "stop condition outside a transaction");
                    check(32'(state), 32'(i2c_pkg::ST_STOP), "state at the stop condition");
                    in_txn   = 1'b0;
                    stop_cnt = stop_cnt + 1;
                end
            end else if (!prev_scl && scl_now && in_txn) begin
                if (bit_cnt < 8) begin
                    shift_in = {shift_in[6:0], sda_now};  // MSB first
                end
                bit_cnt = bit_cnt + 1;
            end else if (prev_scl && !scl_now && in_txn) begin
                if (bit_cnt == 8) begin
                    got_bytes.push_back(shift_in);
                    check(32'(state), (byte_idx == 0) ? 32'(i2c_pkg::ST_ADDRESS) :
                                      (byte_idx == 1) ? 32'(i2c_pkg::ST_CONTROL) :
                                      32'(i2c_pkg::ST_PAYLOAD), "state while a byte is sent");
                    slave_sda_pull = (byte_idx != nack_at);  // ack slot
                end else if (bit_cnt == 9) begin
                    slave_sda_pull = 1'b0;
                    bit_cnt        = 0;
                    // last byte of this transaction, hold SCL before the stop
                    if (byte_idx == nack_at || byte_idx == 2) begin
                        slave_scl_pull = 1'b1;
                        stretch_left   = stretch_ticks;
                    end
                    byte_idx = byte_idx + 1;
                end
            end
            // the stop must not raise SDA while SCL is still held by the slave
            if (!prev_sda && sda_now && slave_scl_pull && !pins.scl_oe) begin
                check(32'd1, 32'd0, "SDA released while SCL is stretched");
            end
            // count the stretch only once the master has let go of SCL
            if (slave_scl_pull && !pins.scl_oe) begin
                if (stretch_left == 0) begin
                    slave_scl_pull = 1'b0;
                end else if (tick_seen) begin
                    stretch_left = stretch_left - 1;
                end
            end
            prev_scl = scl_now;
            prev_sda = sda_now;
        end
    end

    task automatic run_transaction(input int idx);
        logic [31:0]           r;
        i2c_pkg::i2c_request_t req;
        logic [7:0]            exp_bytes [3];
        int                    n_exp;
        draw_bits(7, r);
        req.slave_addr = r[6:0];
        draw_bits(8, r);
        req.control_frame = r[7:0];
        draw_bits(8, r);
        req.reg_addr = r[7:0];
        draw_bits(8, r);
        req.data_write = r[7:0];
        draw_bits(2, r);
        nack_at = (r[1:0] == 2'd0) ? NO_NACK : int'(r[1:0]) - 1;  // 0 addr, 1 ctrl, 2 payload
        draw_bits(2, r);
        stretch_ticks = int'(r[1:0]);

        exp_bytes[0] = {req.slave_addr, 1'b0};  // write
        exp_bytes[1] = req.control_frame;
        exp_bytes[2] = req.control_frame[i2c_pkg::DC_BIT] ? req.data_write : req.reg_addr;
        n_exp = (nack_at == NO_NACK) ? 3 : nack_at + 1;
        if (nack_at == NO_NACK) begin
            if (req.control_frame[i2c_pkg::DC_BIT]) begin
                exp_data_count = exp_data_count + 1'b1;
            end else begin
                exp_command_count = exp_command_count + 1'b1;
            end
        end

        @(posedge CLK);
        #1;
        request = req;
        start   = 1'b1;
        while (!busy) begin
            @(posedge CLK);
            #1;
        end
        start = 1'b0;
        while (busy) begin
            @(posedge CLK);
            #1;
        end

        check(32'(got_bytes.size()), 32'(n_exp), $sformatf("txn %0d byte count", idx));
        for (int b = 0; b < n_exp; b++) begin
            check(32'(got_bytes[b]), 32'(exp_bytes[b]), $sformatf("txn %0d byte %0d", idx, b));
        end
        check(32'(stop_cnt), 32'd1, $sformatf("txn %0d stop conditions", idx));
        check(32'(nack_seen), 32'(nack_at != NO_NACK), $sformatf("txn %0d nack_seen", idx));
        check(32'(command_count), 32'(exp_command_count), "command_count");
        check(32'(data_count), 32'(exp_data_count), "data_count");
        check(32'(state), 32'(i2c_pkg::ST_IDLE), "state after transaction");
        check(32'(pins), 32'd0, "pin enables after transaction");
        check(32'({scl_line, sda_line}), 32'b11, "bus lines idle");
        check(32'(slave_scl_pull), 32'd0, "slave still holding SCL");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        NRST              = 1'b0;
        start             = 1'b0;
        request           = '0;
        nack_at           = NO_NACK;
        stretch_ticks     = 0;
        lfsr_state        = SEED;
        exp_command_count = '0;
        exp_data_count    = '0;

        repeat (16) @(posedge CLK);
        #1;
        // values held by reset
        check(32'(pins), 32'd0, "pin enables in reset");
        check(32'(busy), 32'd0, "busy in reset");
        check(32'(nack_seen), 32'd0, "nack_seen in reset");
        check(32'(command_count), 32'd0, "command_count in reset");
        check(32'(data_count), 32'd0, "data_count in reset");
        check(32'(state), 32'(i2c_pkg::ST_IDLE), "state in reset");
        NRST = 1'b1;

        for (int i = 0; i < N_TXN; i++) begin
            run_transaction(i);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/i2c_bit_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_engine (
    input  wire                    CLK,
    input  wire                    NRST,
    input  wire                    tick,         // quarter phase strobe
    input  wire i2c_pkg::bus_cmd_t cmd,
    input  wire                    cmd_valid,
    input  wire                    scl_in,       // sensed line levels
    input  wire                    sda_in,
    output i2c_pkg::bus_pins_t     pins,
    output logic                   engine_busy,
    output logic                   op_done,
    output logic                   acked         // valid with op_done of a byte
);

    i2c_pkg::bus_op_t                 op;
    logic [i2c_pkg::PHASE_W-1:0]      phase;
    logic [$clog2(i2c_pkg::BYTE_W):0] bit_cnt;  // 0..7 data, 8 = ack slot
    logic [i2c_pkg::BYTE_W-1:0]       shift_reg;

    logic accept;
    logic step;

    assign accept = cmd_valid && !engine_busy;
    assign step   = engine_busy && tick;

    // outgoing byte, MSB leaves first
    always_ff @(posedge CLK) begin
        if (accept) begin
            shift_reg <= cmd.tx_byte;
        end else if (step && op == i2c_pkg::OP_BYTE && phase == 2'd3) begin
            shift_reg <= shift_reg << 1;
        end
    end

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            op          <= i2c_pkg::OP_START;
            phase       <= '0;
            bit_cnt     <= '0;
            engine_busy <= 1'b0;
            op_done     <= 1'b0;
            acked       <= 1'b0;
            pins        <= '0;  // both lines released
        end else begin
            op_done <= 1'b0;
            if (accept) begin
                op          <= cmd.op;
                phase       <= '0;
                bit_cnt     <= '0;
                engine_busy <= 1'b1;
            end else if (step) begin
                phase <= phase + 1'b1;  // overridden while stretching
                case (op)
                    i2c_pkg::OP_START: begin
                        case (phase)
                            2'd0: pins.sda_oe <= 1'b1;  // SDA falls, SCL still high
                            2'd1: pins.scl_oe <= 1'b1;
                            2'd2: ;                     // hold
                            2'd3: begin
                                op_done     <= 1'b1;
                                engine_busy <= 1'b0;
                            end
                        endcase
                    end

                    i2c_pkg::OP_BYTE: begin
                        if (bit_cnt < i2c_pkg::BYTE_W) begin
                            case (phase)
                                // data only moves while SCL is low
                                2'd0: pins.sda_oe <= !shift_reg[i2c_pkg::BYTE_W-1];
                                2'd1: pins.scl_oe <= 1'b0;
                                2'd2: pins.scl_oe <= 1'b1;
                                2'd3: begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                    // hand SDA to the slave before the ack clock
                                    if (bit_cnt == i2c_pkg::BYTE_W - 1) begin
                                        pins.sda_oe <= 1'b0;
                                    end
                                end
                            endcase
                        end else begin
                            case (phase)
                                2'd0: pins.scl_oe <= 1'b0;
                                2'd1: acked <= !sda_in;  // low means ack
                                2'd2: pins.scl_oe <= 1'b1;
                                2'd3: begin
                                    op_done     <= 1'b1;
                                    engine_busy <= 1'b0;
                                end
                            endcase
                        end
                    end

                    i2c_pkg::OP_STOP: begin
                        case (phase)
                            2'd0: pins.sda_oe <= 1'b1;  // SDA low under low SCL
                            2'd1: pins.scl_oe <= 1'b0;
                            2'd2: begin
                                if (scl_in) begin
                                    pins.sda_oe <= 1'b0;  // SDA rises with SCL high
                                end else begin
                                    phase <= phase;       // slave still stretching
                                end
                            end
                            2'd3: begin
                                op_done     <= 1'b1;
                                engine_busy <= 1'b0;
                            end
                        endcase
                    end

                    default: begin
                        // unknown op, just release the bus and finish
                        pins        <= '0;
                        op_done     <= 1'b1;
                        engine_busy <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/i2c_frame_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_frame_ctrl (
    input  wire                        CLK,
    input  wire                        NRST,
    input  wire                        tick,
    input  wire                        start,
    input  wire i2c_pkg::i2c_request_t request,
    input  wire                        engine_busy,
    input  wire                        op_done,
    input  wire                        acked,
    output i2c_pkg::bus_cmd_t          cmd,
    output logic                       cmd_valid,
    output logic                       busy,
    output logic                       nack_seen,
    output logic [i2c_pkg::COUNT_W-1:0] command_count,
    output logic [i2c_pkg::COUNT_W-1:0] data_count,
    output i2c_pkg::frame_state_t      state
);

    i2c_pkg::i2c_request_t      req;  // held for the whole transaction
    i2c_pkg::bus_cmd_t          next_cmd;
    logic [i2c_pkg::BYTE_W-1:0] payload_byte;
    logic                       is_data;
    logic                       issue;

    function automatic i2c_pkg::bus_cmd_t make_cmd(
        input i2c_pkg::bus_op_t           op,
        input logic [i2c_pkg::BYTE_W-1:0] tx_byte
    );
        i2c_pkg::bus_cmd_t c;
        c.op      = op;
        c.tx_byte = tx_byte;
        return c;
    endfunction

    assign is_data      = req.control_frame[i2c_pkg::DC_BIT];
    assign payload_byte = is_data ? req.data_write : req.reg_addr;
    assign busy         = (state != i2c_pkg::ST_IDLE);

    // start accepted in idle on a tick, otherwise each finished op asks for the next
    always_comb begin
        if (state == i2c_pkg::ST_IDLE) begin
            issue = tick && start && !engine_busy;
        end else begin
            issue = op_done && (state != i2c_pkg::ST_STOP);
        end
    end

    always_comb begin
        case (state)
            i2c_pkg::ST_IDLE:
                next_cmd = make_cmd(i2c_pkg::OP_START, 8'h00);
            i2c_pkg::ST_START:
                next_cmd = make_cmd(i2c_pkg::OP_BYTE, {req.slave_addr, 1'b0});  // write
            i2c_pkg::ST_ADDRESS:
                next_cmd = make_cmd(i2c_pkg::OP_BYTE, req.control_frame);
            i2c_pkg::ST_CONTROL:
                next_cmd = make_cmd(i2c_pkg::OP_BYTE, payload_byte);
            default:
                next_cmd = make_cmd(i2c_pkg::OP_STOP, 8'h00);
        endcase
        // nack on any byte goes straight to stop
        if (state != i2c_pkg::ST_IDLE && state != i2c_pkg::ST_START && !acked) begin
            next_cmd = make_cmd(i2c_pkg::OP_STOP, 8'h00);
        end
    end

    always_ff @(posedge CLK) begin
        if (issue) begin
            cmd <= next_cmd;
        end
        if (issue && state == i2c_pkg::ST_IDLE) begin
            req <= request;
        end
    end

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            state         <= i2c_pkg::ST_IDLE;
            cmd_valid     <= 1'b0;
            nack_seen     <= 1'b0;
            command_count <= '0;
            data_count    <= '0;
        end else begin
            cmd_valid <= issue;
            case (state)
                i2c_pkg::ST_IDLE: begin
                    if (issue) begin
                        nack_seen <= 1'b0;
                        state     <= i2c_pkg::ST_START;
                    end
                end
                i2c_pkg::ST_START: begin
                    if (op_done) state <= i2c_pkg::ST_ADDRESS;
                end
                i2c_pkg::ST_ADDRESS: begin
                    if (op_done) begin
                        state     <= acked ? i2c_pkg::ST_CONTROL : i2c_pkg::ST_STOP;
                        nack_seen <= !acked;
                    end
                end
                i2c_pkg::ST_CONTROL: begin
                    if (op_done) begin
                        state     <= acked ? i2c_pkg::ST_PAYLOAD : i2c_pkg::ST_STOP;
                        nack_seen <= !acked;
                    end
                end
                i2c_pkg::ST_PAYLOAD: begin
                    if (op_done) begin
                        state     <= i2c_pkg::ST_STOP;
                        nack_seen <= !acked;
                        if (acked && is_data) begin
                            data_count <= data_count + 1'b1;
                        end else if (acked) begin
                            command_count <= command_count + 1'b1;
                        end
                    end
                end
                i2c_pkg::ST_STOP: begin
                    if (op_done) state <= i2c_pkg::ST_IDLE;  // busy falls here
                end
                default: state <= i2c_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/i2c_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_master (
    input  wire                         CLK,
    input  wire                         NRST,
    input  wire                         tick,     // one-cycle rate strobe
    input  wire                         start,
    input  wire i2c_pkg::i2c_request_t  request,  // stable until busy falls
    input  wire                         scl_in,
    input  wire                         sda_in,
    output wire i2c_pkg::bus_pins_t     pins,     // to the external pads
    output wire                         busy,
    output wire                         nack_seen,
    output wire [i2c_pkg::COUNT_W-1:0]  command_count,
    output wire [i2c_pkg::COUNT_W-1:0]  data_count,
    output wire i2c_pkg::frame_state_t  state
);

    // controller to engine
    wire i2c_pkg::bus_cmd_t cmd;
    wire                    cmd_valid;
    wire                    engine_busy;
    wire                    op_done;
    wire                    acked;

    i2c_frame_ctrl u_frame_ctrl (
        .CLK           (CLK),
        .NRST          (NRST),
        .tick          (tick),
        .start         (start),
        .request       (request),
        .engine_busy   (engine_busy),
        .op_done       (op_done),
        .acked         (acked),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .busy          (busy),
        .nack_seen     (nack_seen),
        .command_count (command_count),
        .data_count    (data_count),
        .state         (state)
    );

    i2c_bit_engine u_bit_engine (
        .CLK         (CLK),
        .NRST        (NRST),
        .tick        (tick),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .scl_in      (scl_in),
        .sda_in      (sda_in),
        .pins        (pins),
        .engine_busy (engine_busy),
        .op_done     (op_done),
        .acked       (acked)
    );

endmodule

`default_nettype wire

// ==== source/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

    localparam int ADDR_W  = 7;  // 7-bit slave address
    localparam int BYTE_W  = 8;
    localparam int COUNT_W = 8;  // acked byte counters, wrap around
    localparam int DC_BIT  = 6;  // D/C# position in the control byte
    localparam int PHASE_W = 2;  // four quarters per bit

    // operations the bit engine knows
    typedef enum logic [1:0] {
        OP_START,
        OP_BYTE,
        OP_STOP
    } bus_op_t;

    // transaction states, also visible at the top level
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_ADDRESS,
        ST_CONTROL,
        ST_PAYLOAD,
        ST_STOP
    } frame_state_t;

    typedef struct packed {
        logic [ADDR_W-1:0] slave_addr;
        logic [BYTE_W-1:0] control_frame;  // Co and D/C# bits
        logic [BYTE_W-1:0] reg_addr;       // sent when D/C# is 0
        logic [BYTE_W-1:0] data_write;     // sent when D/C# is 1
    } i2c_request_t;

    typedef struct packed {
        bus_op_t           op;
        logic [BYTE_W-1:0] tx_byte;  // only meaningful for OP_BYTE
    } bus_cmd_t;

    // open-drain enables, high pulls the line low
    typedef struct packed {
        logic scl_oe;
        logic sda_oe;
    } bus_pins_t;

endpackage

`default_nettype wire
